// ==== sim.f ====
+incdir+tests
hdl/mos_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/exec_ctrl.sv
hdl/exec_top.sv
tests/exec_tb.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - files:
      - hdl/mos_pkg.sv
      - hdl/alu.sv
      - hdl/reg_file.sv
      - hdl/exec_ctrl.sv
      - hdl/exec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/exec_tb.sv

// ==== tests/exec_model.svh ====
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

`default_nettype none

// True for the opcodes that retire into their destination register.
function automatic logic model_writes_dst(input mos_pkg::alu_op_e op);
    return op inside {mos_pkg::ORA, mos_pkg::AND, mos_pkg::EOR,
                      mos_pkg::ADC, mos_pkg::SBC, mos_pkg::LDA};
endfunction

// Byte result of one micro-operation, worked out in integer arithmetic.
function automatic logic [7:0] model_result(input mos_pkg::alu_op_e op, input logic [7:0] a,
                                            input logic [7:0] b, input logic [7:0] p);
    int ia;
    int ib;
    int cin;
    int tmp;
    ia  = a;
    ib  = b;
    cin = p[mos_pkg::flag_c];
    case (op)
        mos_pkg::ORA: tmp = a | b;
        mos_pkg::AND: tmp = a & b;
        mos_pkg::EOR: tmp = a ^ b;
        mos_pkg::ADC: tmp = ia + ib + cin;
        mos_pkg::STA: tmp = ia;            // store data is the source itself.
        mos_pkg::LDA: tmp = ib;
        mos_pkg::CMP: tmp = ia - ib;
        mos_pkg::SBC: tmp = ia - ib - (1 - cin);  // a clear carry means borrow.
        mos_pkg::ADD: tmp = ia + ib;
        default:      tmp = 0;
    endcase
    return tmp[7:0];
endfunction

// New status register after one micro-operation.
function automatic logic [7:0] model_flags(input mos_pkg::alu_op_e op, input logic [7:0] a,
                                           input logic [7:0] b, input logic [7:0] p);
    logic [7:0] f;
    logic [7:0] r;
    int         ia;
    int         ib;
    int         sa;
    int         sb;
    int         cin;
    f   = p;
    r   = model_result(op, a, b, p);
    ia  = a;
    ib  = b;
    sa  = $signed(a);
    sb  = $signed(b);
    cin = p[mos_pkg::flag_c];
    if (op inside {mos_pkg::ORA, mos_pkg::AND, mos_pkg::EOR, mos_pkg::LDA,
                   mos_pkg::ADC, mos_pkg::SBC, mos_pkg::CMP}) begin
        f[mos_pkg::flag_n] = r[7];
        f[mos_pkg::flag_z] = (r == 8'h00);
    end
    case (op)
        mos_pkg::ADC: begin
            f[mos_pkg::flag_c] = (ia + ib + cin) > 255;
            f[mos_pkg::flag_v] = ((sa + sb + cin) > 127) || ((sa + sb + cin) < -128);
        end
        mos_pkg::SBC: begin
            f[mos_pkg::flag_c] = (ia - ib - (1 - cin)) >= 0;
            f[mos_pkg::flag_v] = ((sa - sb - (1 - cin)) > 127) || ((sa - sb - (1 - cin)) < -128);
        end
        mos_pkg::CMP: f[mos_pkg::flag_c] = (ia >= ib);
        mos_pkg::ADD: f[mos_pkg::flag_c] = (ia + ib) > 255;  // nothing else moves.
        default: ;
    endcase
    return f;
endfunction

`default_nettype wire

`endif

// ==== tests/exec_tb.sv ====
`include "exec_model.svh"

`default_nettype none

module exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import mos_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 10;
    localparam int N_DIRECTED   = 30;
    localparam int N_RANDOM     = 40;

    typedef struct packed {
        alu_op_e    op;
        reg_sel_e   src;
        reg_sel_e   dst;
        logic [7:0] operand;
    } stim_t;

    typedef struct packed {
        alu_op_e     op;
        logic [7:0]  a;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  p;
        logic [7:0]  data;  // store data or effective address.
        logic [31:0] due;   // cycle in which done must be seen.
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       op_valid;
    alu_op_e    op;
    reg_sel_e   src;
    reg_sel_e   dst;
    logic [7:0] operand;
    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] p;
    logic       store_valid;
    logic [7:0] store_data;
    logic       ea_valid;
    logic [7:0] ea;
    logic       done;

    stim_t      stim_q[$];
    expect_t    exp_q[$];
    logic [7:0] sh_a;
    logic [7:0] sh_x;
    logic [7:0] sh_y;
    logic [7:0] sh_p;
    int         cycle          = 0;
    int         seed           = 79167;
    int         mismatch_count = 0;
    int         protocol_count = 0;

    exec_top #(
        .DATA_W (8)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .op          (op),
        .src         (src),
        .dst         (dst),
        .operand     (operand),
        .a           (a),
        .x           (x),
        .y           (y),
        .p           (p),
        .store_valid (store_valid),
        .store_data  (store_data),
        .ea_valid    (ea_valid),
        .ea          (ea),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_byte(input string name, input logic [7:0] exp_val,
                              input logic [7:0] act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH t=%0t %s exp=%02h act=%02h", $time, name, exp_val, act_val);
            mismatch_count++;
        end
    endtask

    task automatic check_flags(input logic [7:0] exp_val, input logic [7:0] act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH t=%0t p exp=%08b act=%08b", $time, exp_val, act_val);
            mismatch_count++;
        end
    endtask

    task automatic check_op_kind(input alu_op_e kind, input logic sv, input logic ev);
        logic exp_sv;
        logic exp_ev;
        exp_sv = (kind == STA);
        exp_ev = (kind == ADD);
        if (sv !== exp_sv) begin
            $display("MISMATCH t=%0t store_valid exp=%b act=%b (op %s)",
                     $time, exp_sv, sv, kind.name());
            mismatch_count++;
        end
        if (ev !== exp_ev) begin
            $display("MISMATCH t=%0t ea_valid exp=%b act=%b (op %s)",
                     $time, exp_ev, ev, kind.name());
            mismatch_count++;
        end
    endtask

    task automatic add_entry(input alu_op_e o, input reg_sel_e s, input reg_sel_e d,
                             input logic [7:0] v);
        stim_t e;
        e.op      = o;
        e.src     = s;
        e.dst     = d;
        e.operand = v;
        stim_q.push_back(e);
    endtask

    task automatic build_directed();
        add_entry(LDA, REG_A, REG_A,    8'h55);
        add_entry(LDA, REG_A, REG_X,    8'h80);  // negative load.
        add_entry(LDA, REG_A, REG_Y,    8'h00);  // zero load.
        add_entry(ORA, REG_A, REG_A,    8'h0a);
        add_entry(AND, REG_A, REG_A,    8'hf0);
        add_entry(EOR, REG_A, REG_A,    8'hff);
        add_entry(EOR, REG_X, REG_Y,    8'h80);
        add_entry(AND, REG_X, REG_X,    8'h7f);
        add_entry(ORA, REG_Y, REG_X,    8'h81);
        add_entry(LDA, REG_A, REG_A,    8'h01);
        add_entry(CMP, REG_A, REG_NONE, 8'h01);  // equal, sets carry for the next add.
        add_entry(ADC, REG_A, REG_A,    8'hff);
        add_entry(ADC, REG_A, REG_A,    8'h7f);  // signed overflow.
        add_entry(ADC, REG_A, REG_A,    8'h80);
        add_entry(SBC, REG_A, REG_A,    8'h01);
        add_entry(SBC, REG_A, REG_A,    8'h01);  // borrow out.
        add_entry(SBC, REG_A, REG_A,    8'h00);
        add_entry(SBC, REG_A, REG_X,    8'h7f);
        add_entry(CMP, REG_X, REG_NONE, 8'h80);
        add_entry(CMP, REG_A, REG_NONE, 8'h10);
        add_entry(STA, REG_A, REG_NONE, 8'h00);
        add_entry(STA, REG_X, REG_NONE, 8'h00);
        add_entry(ADD, REG_X, REG_NONE, 8'h90);  // address wraps past 255.
        add_entry(ADD, REG_Y, REG_NONE, 8'h20);
        add_entry(LDA, REG_A, REG_Y,    8'hc3);
        add_entry(STA, REG_Y, REG_NONE, 8'h00);  // stores the value loaded one cycle earlier.
        add_entry(ADC, REG_Y, REG_Y,    8'h3d);
        add_entry(ADC, REG_Y, REG_A,    8'h00);
        add_entry(ADD, REG_A, REG_NONE, 8'hff);
        add_entry(EOR, REG_A, REG_A,    8'h01);
    endtask

    task automatic build_random();
        logic [31:0] rnd;
        alu_op_e     o;
        reg_sel_e    s;
        reg_sel_e    d;
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            o   = alu_op_e'(4'(rnd[7:0] % 9));
            s   = reg_sel_e'(2'(rnd[9:8] % 3));
            d   = reg_sel_e'(2'(rnd[11:10] % 3));
            if (o inside {CMP, STA, ADD}) begin
                d = REG_NONE;
            end
            add_entry(o, s, d, rnd[23:16]);
        end
    endtask

    // Steps the shadow registers through one entry and queues what retirement must show.
    task automatic predict(input stim_t s);
        expect_t    e;
        logic [7:0] src_val;
        logic [7:0] res;
        case (s.src)
            REG_A:   src_val = sh_a;
            REG_X:   src_val = sh_x;
            REG_Y:   src_val = sh_y;
            default: src_val = 8'h00;
        endcase
        res = model_result(s.op, src_val, s.operand, sh_p);
        if (model_writes_dst(s.op)) begin
            case (s.dst)
                REG_A:   sh_a = res;
                REG_X:   sh_x = res;
                REG_Y:   sh_y = res;
                default: ;
            endcase
        end
        sh_p   = model_flags(s.op, src_val, s.operand, sh_p);
        e.op   = s.op;
        e.a    = sh_a;
        e.x    = sh_x;
        e.y    = sh_y;
        e.p    = sh_p;
        e.data = res;
        e.due  = cycle + 2;  // issue edge next, then the retire edge.
        exp_q.push_back(e);
    endtask

    always @(negedge clk) begin : monitor
        expect_t e;
        if (rst_n) begin
            if (done === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR t=%0t done pulse with no pending micro-operation", $time);
                    protocol_count++;
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != cycle) begin
                        $display("ERROR t=%0t done for %s came in cycle %0d instead of %0d",
                                 $time, e.op.name(), cycle, e.due);
                        protocol_count++;
                    end
                    check_byte("a", e.a, a);
                    check_byte("x", e.x, x);
                    check_byte("y", e.y, y);
                    check_flags(e.p, p);
                    check_op_kind(e.op, store_valid, ea_valid);
                    if (e.op == STA) begin
                        check_byte("store_data", e.data, store_data);
                    end
                    if (e.op == ADD) begin
                        check_byte("ea", e.data, ea);
                    end
                end
            end else begin
                if ((exp_q.size() != 0) && (exp_q[0].due <= cycle)) begin
                    e = exp_q.pop_front();
                    $display("ERROR t=%0t no done seen for %s due in cycle %0d",
                             $time, e.op.name(), e.due);
                    protocol_count++;
                end
                if ((store_valid !== 1'b0) || (ea_valid !== 1'b0)) begin
                    $display("ERROR t=%0t store or address strobe high without done", $time);
                    protocol_count++;
                end
            end
        end
    end

    initial begin
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op       = ORA;
        src      = REG_A;
        dst      = REG_A;
        operand  = 8'h00;
        sh_a     = 8'h00;
        sh_x     = 8'h00;
        sh_y     = 8'h00;
        sh_p     = P_RESET;
        build_directed();
        build_random();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        @(negedge clk);
        check_byte("a", 8'h00, a);
        check_byte("x", 8'h00, x);
        check_byte("y", 8'h00, y);
        check_flags(P_RESET, p);
        foreach (stim_q[i]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            op_valid = 1'b1;
            op       = stim_q[i].op;
            src      = stim_q[i].src;
            dst      = stim_q[i].dst;
            operand  = stim_q[i].operand;
            predict(stim_q[i]);
        end
        @(posedge clk);
        #DRIVE_DELAY op_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);  // catch a stray done after the last entry.
        $display("errors: %0d mismatches, %0d protocol errors", mismatch_count, protocol_count);
        if ((mismatch_count == 0) && (protocol_count == 0)) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((N_DIRECTED + N_RANDOM + RESET_CYCLES + 10) * CLK_PERIOD);
        $display("ERROR t=%0t the run did not finish in time", $time);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/exec_top.sv ====
`default_nettype none

module exec_top #(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_valid,
    input  mos_pkg::alu_op_e  op,
    input  mos_pkg::reg_sel_e src,
    input  mos_pkg::reg_sel_e dst,
    input  logic [7:0]        operand,
    output logic [DATA_W-1:0] a,
    output logic [DATA_W-1:0] x,
    output logic [DATA_W-1:0] y,
    output logic [7:0]        p,
    output logic              store_valid,
    output logic [7:0]        store_data,
    output logic              ea_valid,
    output logic [7:0]        ea,
    output logic              done
);
    import mos_pkg::*;

    alu_op_e           alu_op;
    logic [7:0]        alu_a;
    logic [7:0]        alu_b;
    logic [7:0]        alu_p;
    logic [7:0]        alu_res;
    logic [7:0]        alu_flag;
    logic              wr_en;
    reg_sel_e          wr_sel;
    logic [DATA_W-1:0] wr_data;
    logic              flag_we;
    logic [7:0]        flag_data;

    reg_file #(
        .DATA_W (DATA_W)
    ) reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_data   (wr_data),
        .flag_we   (flag_we),
        .flag_data (flag_data),
        .reg_a     (a),
        .reg_x     (x),
        .reg_y     (y),
        .reg_p     (p)
    );

    exec_ctrl exec_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .op          (op),
        .src         (src),
        .dst         (dst),
        .operand     (operand),
        .reg_a       (a),
        .reg_x       (x),
        .reg_y       (y),
        .reg_p       (p),
        .alu_op      (alu_op),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_p       (alu_p),
        .alu_res     (alu_res),
        .alu_flag    (alu_flag),
        .wr_en       (wr_en),
        .wr_sel      (wr_sel),
        .wr_data     (wr_data),
        .flag_we     (flag_we),
        .flag_data   (flag_data),
        .store_valid (store_valid),
        .store_data  (store_data),
        .ea_valid    (ea_valid),
        .ea          (ea),
        .done        (done)
    );

    alu alu_i (
        .alu_op   (alu_op),
        .a_in     (alu_a),
        .b_in     (alu_b),
        .p_in     (alu_p),
        .alu_res  (alu_res),
        .alu_flag (alu_flag)
    );

endmodule

`default_nettype wire

// ==== hdl/exec_ctrl.sv ====
`default_nettype none

module exec_ctrl (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_valid,
    input  mos_pkg::alu_op_e  op,
    input  mos_pkg::reg_sel_e src,
    input  mos_pkg::reg_sel_e dst,
    input  logic [7:0]        operand,
    input  logic [7:0]        reg_a,
    input  logic [7:0]        reg_x,
    input  logic [7:0]        reg_y,
    input  logic [7:0]        reg_p,
    output mos_pkg::alu_op_e  alu_op,
    output logic [7:0]        alu_a,
    output logic [7:0]        alu_b,
    output logic [7:0]        alu_p,
    input  logic [7:0]        alu_res,
    input  logic [7:0]        alu_flag,
    output logic              wr_en,
    output mos_pkg::reg_sel_e wr_sel,
    output logic [7:0]        wr_data,
    output logic              flag_we,
    output logic [7:0]        flag_data,
    output logic              store_valid,
    output logic [7:0]        store_data,
    output logic              ea_valid,
    output logic [7:0]        ea,
    output logic              done
);
    import mos_pkg::*;

    logic       iss_valid;
    alu_op_e    iss_op;
    reg_sel_e   iss_src;
    reg_sel_e   iss_dst;
    logic [7:0] iss_operand;
    logic       wb_dst;
    logic       wb_flag;
    logic       is_store;
    logic       is_ea;

    // Issue register for the micro-operation in the ALU stage.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            iss_op      <= op;
            iss_src     <= src;
            iss_dst     <= dst;
            iss_operand <= operand;
        end
    end

    // Registers are written on the edge that issues the next op, so the
    // plain register outputs are already current and no bypass is needed.
    always_comb begin
        case (iss_src)
            REG_A:   alu_a = reg_a;
            REG_X:   alu_a = reg_x;
            REG_Y:   alu_a = reg_y;
            default: alu_a = 8'h00;
        endcase
    end

    assign alu_op = iss_op;
    assign alu_b  = iss_operand;
    assign alu_p  = reg_p;

    always_comb begin
        wb_dst   = 1'b0;
        wb_flag  = 1'b0;
        is_store = 1'b0;
        is_ea    = 1'b0;
        case (iss_op)
            ORA, AND, EOR, ADC, SBC, LDA: begin
                wb_dst  = 1'b1;
                wb_flag = 1'b1;
            end
            CMP:     wb_flag = 1'b1;
            STA:     is_store = 1'b1;
            ADD: begin
                wb_flag = 1'b1;
                is_ea   = 1'b1;
            end
            default: ;
        endcase
    end

    assign wr_en   = iss_valid && wb_dst;
    assign wr_sel  = iss_dst;
    assign wr_data = alu_res;
    assign flag_we = iss_valid && wb_flag;

    // the ALU already limits an address add to the carry bit.
    assign flag_data = alu_flag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done        <= 1'b0;
            store_valid <= 1'b0;
            ea_valid    <= 1'b0;
        end else begin
            done        <= iss_valid;
            store_valid <= iss_valid && is_store;
            ea_valid    <= iss_valid && is_ea;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && is_store) begin
            store_data <= alu_res;  // the ALU passes the source register through.
        end
        if (iss_valid && is_ea) begin
            ea <= alu_res;
        end
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(store_valid && ea_valid)
    ) else $error("store and address strobes high together");

    a_done_timing: assert property (
        @(posedge clk) disable iff (!rst_n)
        op_valid |-> ##2 done
    ) else $error("done did not follow op_valid");

    a_no_dst: assert property (
        @(posedge clk) disable iff (!rst_n)
        (op_valid && (op inside {CMP, STA, ADD})) |-> (dst == REG_NONE)
    ) else $error("CMP, STA or ADD issued with a destination register");

    a_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        iss_valid |-> !$isunknown(alu_op)
    ) else $error("ALU opcode unknown while in use");

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file #(
    parameter int DATA_W = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  mos_pkg::reg_sel_e   wr_sel,
    input  logic [DATA_W-1:0]   wr_data,
    input  logic                flag_we,
    input  logic [7:0]          flag_data,
    output logic [DATA_W-1:0]   reg_a,
    output logic [DATA_W-1:0]   reg_x,
    output logic [DATA_W-1:0]   reg_y,
    output logic [7:0]          reg_p
);
    import mos_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_a <= '0;
            reg_x <= '0;
            reg_y <= '0;
        end else if (wr_en) begin
            case (wr_sel)
                REG_A:   reg_a <= wr_data;
                REG_X:   reg_x <= wr_data;
                REG_Y:   reg_y <= wr_data;
                default: ;  // no data register is selected.
            endcase
        end
    end

    // The status register has its own write port so a data write and a
    // flag write can land on the same edge.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_p <= P_RESET;
        end else if (flag_we) begin
            reg_p <= flag_data;
        end
    end

    // The control block must never request a data write without a target.
    a_wr_target: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_sel != REG_NONE)
    ) else $error("data write with no register selected");

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu (
    input  mos_pkg::alu_op_e alu_op,
    input  logic [7:0]       a_in,
    input  logic [7:0]       b_in,
    input  logic [7:0]       p_in,
    output logic [7:0]       alu_res,
    output logic [7:0]       alu_flag
);
    import mos_pkg::*;

    logic [8:0] rs;  // bit 8 holds the carry or the borrow.
    logic [7:0] fl;

    assign alu_res  = rs[7:0];
    assign alu_flag = fl;

    always_comb begin
        rs = 9'd0;
        fl = p_in;  // untouched bits pass through.
        case (alu_op)
            ORA: begin
                rs         = {1'b0, a_in | b_in};
                fl[flag_n] = rs[7];
                fl[flag_z] = ~|rs[7:0];
            end
            AND: begin
                rs         = {1'b0, a_in & b_in};
                fl[flag_n] = rs[7];
                fl[flag_z] = ~|rs[7:0];
            end
            EOR: begin
                rs         = {1'b0, a_in ^ b_in};
                fl[flag_n] = rs[7];
                fl[flag_z] = ~|rs[7:0];
            end
            ADC: begin
                rs         = {1'b0, a_in} + {1'b0, b_in} + {8'd0, p_in[flag_c]};
                fl[flag_n] = rs[7];
                // overflow when both inputs share a sign that the sum loses.
                fl[flag_v] = (a_in[7] ~^ b_in[7]) & (a_in[7] ^ rs[7]);
                fl[flag_z] = ~|rs[7:0];  // zero looks at the byte result only.
                fl[flag_c] = rs[8];
            end
            STA: begin
                rs = {1'b0, a_in};  // the source register goes out as store data.
            end
            LDA: begin
                rs         = {1'b0, b_in};
                fl[flag_n] = b_in[7];
                fl[flag_z] = ~|b_in;
            end
            CMP: begin
                rs         = {1'b0, a_in} - {1'b0, b_in};
                fl[flag_n] = rs[7];
                fl[flag_z] = ~|rs[7:0];
                fl[flag_c] = ~rs[8];  // carry set means no borrow.
            end
            SBC: begin
                rs         = {1'b0, a_in} - {1'b0, b_in} - {8'd0, ~p_in[flag_c]};
                fl[flag_n] = rs[7];
                // operands of opposite sign and the result takes the sign of b.
                fl[flag_v] = (a_in[7] ^ b_in[7]) & (a_in[7] ^ rs[7]);
                fl[flag_z] = ~|rs[7:0];
                fl[flag_c] = ~rs[8];
            end
            ADD: begin
                rs         = {1'b0, a_in} + {1'b0, b_in};
                fl[flag_c] = rs[8];  // only the carry moves for address adds.
            end
            default: begin
                rs = 9'd0;  // codes above 8 do nothing.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mos_pkg.sv ====
`default_nettype none

package mos_pkg;

    // ALU opcodes as the decoder hands them over.
    typedef enum logic [3:0] {
        ORA = 4'd0,  // bitwise or.
        AND = 4'd1,  // bitwise and.
        EOR = 4'd2,  // bitwise exclusive or.
        ADC = 4'd3,  // add with carry.
        STA = 4'd4,  // store covers STA, STX and STY.
        LDA = 4'd5,  // load covers LDA, LDX and LDY.
        CMP = 4'd6,  // compare covers CMP, CPX and CPY.
        SBC = 4'd7,  // subtract with inverted borrow.
        ADD = 4'd8   // plain add for effective addresses.
    } alu_op_e;

    // Register select, used both as source and as destination.
    typedef enum logic [1:0] {
        REG_A    = 2'd0,
        REG_X    = 2'd1,
        REG_Y    = 2'd2,
        REG_NONE = 2'd3
    } reg_sel_e;

    localparam int flag_n = 7;  // negative.
    localparam int flag_v = 6;  // overflow.
    localparam int flag_z = 1;  // zero.
    localparam int flag_c = 0;  // carry.

    localparam logic [7:0] P_RESET = 8'h20;  // bit 5 is unused and reads as one.

endpackage

`default_nettype wire
